/* project.f */
rtl/mips_pkg.sv
rtl/pipe_ctrl_if.sv
rtl/hazard_detection.sv
rtl/control_decoder.sv
rtl/register_file.sv
rtl/alu.sv
rtl/mips_pipeline.sv
rtl/mips_core_top.sv
dv/mips_core_assert.sv
dv/tb_mips_core.sv

/* dv/tb_mips_core.sv */
`timescale 1ns/10ps

module tb_mips_core;
    import mips_pkg::*;

    localparam int NUM_TESTS = 10;
    localparam int MAX_LEN   = 64;   // Longest program, fits imem

    logic        clk, rst_n, imem_we;
    logic [7:0]  imem_addr;          // $clog2(256)
    logic [31:0] imem_wdata;
    logic        wb_valid, mem_we, halted;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data, mem_addr, mem_wdata;

    logic [31:0] prog [MAX_LEN];
    logic [4:0]  wdest [MAX_LEN];    // Destination per slot, 0 for none
    logic        no_beq [MAX_LEN];   // Slots too close after a branch target
    logic [31:0] model_regs [32];
    logic [31:0] model_dmem [64];

    logic [4:0]  exp_wb_rd [$];
    logic [31:0] exp_wb_data [$];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];

    int   errors = 0;
    int   tests_failed = 0;
    int   tests_run = 0;
    int   wb_count, st_count;
    logic running = 1'b0;
    logic halted_seen = 1'b0;
    logic timed_out = 1'b0;          // No halt within the cycle limit

    mips_core_top #(
        .IMEM_DEPTH (256),
        .DMEM_DEPTH (64)
    ) uut (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_imem_we    (imem_we),
        .i_imem_addr  (imem_addr),
        .i_imem_wdata (imem_wdata),
        .o_wb_valid   (wb_valid),
        .o_wb_rd      (wb_rd),
        .o_wb_data    (wb_data),
        .o_mem_we     (mem_we),
        .o_mem_addr   (mem_addr),
        .o_mem_wdata  (mem_wdata),
        .o_halted     (halted)
    );

    bind hazard_detection mips_core_assert u_assert (
        .i_clk         (tb_mips_core.clk),
        .i_rst_n       (tb_mips_core.rst_n),
        .i_stall       (o_ctrl.stall),
        .i_flush_id_ex (o_ctrl.flush_id_ex),
        .i_flush_if_id (o_ctrl.flush_if_id),
        .i_take_branch (i_id_take_branch)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    function automatic logic [31:0] enc_r(funct_e fn, logic [4:0] rd, logic [4:0] rs,
                                          logic [4:0] rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(opcode_e op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // BEQ compare has no forwarding, so its operands must be settled
    function automatic logic written_recently(int p, logic [4:0] r);
        logic hit;
        hit = 1'b0;
        for (int k = 1; k <= 3; k++) begin
            if (p - k >= 0 && r != 0 && wdest[p-k] == r) hit = 1'b1;
        end
        return hit;
    endfunction

    // Jumping in right before a BEQ would hide its real predecessors
    task automatic mark_target(input int tgt, input int n);
        for (int k = 0; k < 3; k++) begin
            if (tgt + k < n) no_beq[tgt+k] = 1'b1;
        end
    endtask

    task automatic gen_program(input int n);
        int          kind, tgt;
        logic [4:0]  rd, rs, rt;
        funct_e      fn;
        for (int p = 0; p < n; p++) no_beq[p] = 1'b0;
        for (int p = 0; p < n - 1; p++) begin
            kind     = $urandom % 10;
            rd       = 5'($urandom % 8);  // Few registers, many dependences
            rs       = 5'($urandom % 8);
            rt       = 5'($urandom % 8);
            wdest[p] = '0;
            if (kind == 8 && p <= n - 4 && !no_beq[p]) begin
                if ($urandom % 2) rt = rs;  // Equal operands, taken
                if (written_recently(p, rs) || written_recently(p, rt)) begin
                    rs = '0;
                    rt = '0;
                end
                tgt     = p + 3 + int'($urandom % (n - p - 3));  // Forward only
                prog[p] = enc_i(OP_BEQ, rs, rt, 16'(tgt - p - 1));
                mark_target(tgt, n);
            end else if (kind == 9 && p <= n - 4) begin
                tgt     = p + 3 + int'($urandom % (n - p - 3));
                prog[p] = {OP_J, 26'(tgt)};
                mark_target(tgt, n);
            end else if (kind < 4) begin
                case ($urandom % 5)
                    0:       fn = FN_ADDU;
                    1:       fn = FN_SUBU;
                    2:       fn = FN_AND;
                    3:       fn = FN_OR;
                    default: fn = FN_SLT;
                endcase
                prog[p]  = enc_r(fn, rd, rs, rt);
                wdest[p] = rd;
            end else if (kind == 6) begin
                prog[p]  = enc_i(OP_LW, '0, rt, 16'(4 * ($urandom % 8)));  // Small address set
                wdest[p] = rt;
            end else if (kind == 7) begin
                prog[p] = enc_i(OP_SW, '0, rt, 16'(4 * ($urandom % 8)));
            end else begin
                prog[p]  = enc_i(OP_ADDIU, rs, rt, 16'($urandom));
                wdest[p] = rt;
            end
        end
        prog[n-1] = {OP_HALT, 26'd0};
    endtask

    task automatic record_write(input logic [4:0] rd, input logic [31:0] val);
        if (rd != 0) model_regs[rd] = val;
        exp_wb_rd.push_back(rd);
        exp_wb_data.push_back((rd == 0) ? 32'd0 : val);  // $0 stays zero
    endtask

    // Instruction-level model, one instruction per step
    task automatic run_model(input int n);
        logic [31:0] instr, a, b, val;
        int          pc, steps;
        logic        done;
        exp_wb_rd.delete();
        exp_wb_data.delete();
        exp_st_addr.delete();
        exp_st_data.delete();
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        for (int i = 0; i < 64; i++) model_dmem[i] = '0;
        pc    = 0;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < n) begin
            instr = prog[pc];
            a     = model_regs[instr[25:21]];
            b     = model_regs[instr[20:16]];
            val   = a + {{16{instr[15]}}, instr[15:0]};  // ADDIU sum or byte address
            pc    = pc + 1;
            steps = steps + 1;
            case (instr[31:26])
                OP_RTYPE: begin
                    case (instr[5:0])
                        FN_ADDU: val = a + b;
                        FN_SUBU: val = a - b;
                        FN_AND:  val = a & b;
                        FN_OR:   val = a | b;
                        default: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    endcase
                    record_write(instr[15:11], val);
                end
                OP_ADDIU: record_write(instr[20:16], val);
                OP_LW:    record_write(instr[20:16], model_dmem[val[7:2]]);  // 64 words
                OP_SW: begin
                    model_dmem[val[7:2]] = b;
                    exp_st_addr.push_back(val);
                    exp_st_data.push_back(b);
                end
                OP_BEQ:   if (a == b) pc = pc + $signed(instr[15:0]);
                OP_J:     pc = int'(instr[25:0]);
                OP_HALT:  done = 1'b1;
                default:  done = done;
            endcase
        end
    endtask

    // Trace checker, outputs are stable at the falling edge
    always @(negedge clk) begin
        if (running) begin
            if (wb_valid) begin
                wb_count++;
                if (halted_seen) begin
                    errors++;
                    $display("ERROR at %0t: writeback strobe after o_halted", $time);
                end else if (exp_wb_rd.size() == 0) begin
                    errors++;
                    $display("ERROR at %0t: writeback to r%0d not in the model", $time, wb_rd);
                end else begin
                    if (wb_rd !== exp_wb_rd[0] || wb_data !== exp_wb_data[0]) begin
                        errors++;
                        $display("FAIL %0t: writeback r%0d = %h, expected r%0d = %h",
                                 $time, wb_rd, wb_data, exp_wb_rd[0], exp_wb_data[0]);
                    end
                    exp_wb_rd.delete(0);
                    exp_wb_data.delete(0);
                end
            end
            if (mem_we) begin
                st_count++;
                if (halted_seen) begin
                    errors++;
                    $display("ERROR at %0t: store strobe after o_halted", $time);
                end else if (exp_st_addr.size() == 0) begin
                    errors++;
                    $display("ERROR at %0t: store to %h not in the model", $time, mem_addr);
                end else begin
                    if (mem_addr !== exp_st_addr[0] || mem_wdata !== exp_st_data[0]) begin
                        errors++;
                        $display("FAIL %0t: store [%h] = %h, expected [%h] = %h",
                                 $time, mem_addr, mem_wdata, exp_st_addr[0], exp_st_data[0]);
                    end
                    exp_st_addr.delete(0);
                    exp_st_data.delete(0);
                end
            end
            if (halted_seen && !halted) begin
                errors++;
                $display("ERROR at %0t: o_halted dropped after rising", $time);
            end
            if (halted) halted_seen = 1'b1;
        end
    end

    task automatic run_test(input int idx, input int n);
        int limit, cycles, err_start;
        err_start = errors;
        limit     = n * 3 + 50;
        tests_run++;
        gen_program(n);
        run_model(n);
        @(negedge clk);
        running     = 1'b0;
        rst_n       = 1'b0;
        halted_seen = 1'b0;
        wb_count    = 0;
        st_count    = 0;
        for (int i = 0; i < n; i++) begin  // One word per cycle under reset
            imem_we    = 1'b1;
            imem_addr  = 8'(i);
            imem_wdata = prog[i];
            @(negedge clk);
        end
        imem_we = 1'b0;
        repeat (3) @(negedge clk);
        if (wb_valid || mem_we || halted) begin
            errors++;
            $display("ERROR at %0t: trace outputs not low during reset", $time);
        end
        rst_n   = 1'b1;
        running = 1'b1;
        cycles  = 0;
        while (!halted && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            running   = 1'b0;
            timed_out = 1'b1;
            errors++;
            tests_failed++;
            $display("ERROR at %0t: test %0d timed out, no halt within %0d cycles",
                     $time, idx, limit);
        end else begin
            repeat (8) @(negedge clk);  // Quiet window after HALT retires
            running = 1'b0;
            if (exp_wb_rd.size() != 0 || exp_st_addr.size() != 0) begin
                errors++;
                $display("ERROR at %0t: test %0d missed %0d writebacks and %0d stores",
                         $time, idx, exp_wb_rd.size(), exp_st_addr.size());
            end
            if (errors == err_start) begin
                $display("test %0d: ok, %0d instructions, %0d writebacks, %0d stores",
                         idx, n, wb_count, st_count);
            end else begin
                tests_failed++;
                $display("test %0d: %0d errors", idx, errors - err_start);
            end
        end
    endtask

    initial begin
        int total_errors;
        rst_n      = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        void'($urandom(25));
        for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
            run_test(t, 16 + int'($urandom % 40));
        end
        total_errors = errors + uut.u_hazard.u_assert.fail_count;
        $display("tests %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors,
                 uut.u_hazard.u_assert.fail_count);
        if (total_errors == 0 && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* dv/mips_core_assert.sv */
`timescale 1ns/10ps

// Checks on the hazard levels, bound into hazard_detection
module mips_core_assert (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_stall,
    input logic i_flush_id_ex,
    input logic i_flush_if_id,
    input logic i_take_branch
);

    int fail_count = 0;  // Failed checks so far

    // A taken branch moves on, so it never waits on a stall
    a_stall_excludes_if_flush: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !(i_stall && i_flush_if_id)
    ) else begin
        fail_count++;
        $error("stall and IF/ID flush high in the same cycle");
    end

    a_stall_bubbles_ex: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) i_stall |-> i_flush_id_ex
    ) else begin
        fail_count++;
        $error("stall without a bubble into ID/EX");
    end

    // Bubble without a stall only on a redirect
    a_id_ex_flush_needs_stall: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) (i_flush_id_ex && !i_take_branch) |-> i_stall
    ) else begin
        fail_count++;
        $error("ID/EX flush with neither stall nor taken branch");
    end

endmodule

/* rtl/mips_core_top.sv */
`timescale 1ns/10ps

module mips_core_top #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 64
) (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_imem_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0]   i_imem_addr,
    input  logic [mips_pkg::XLEN-1:0]       i_imem_wdata,
    output logic                            o_wb_valid,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_wb_rd,
    output logic [mips_pkg::XLEN-1:0]       o_wb_data,
    output logic                            o_mem_we,
    output logic [mips_pkg::XLEN-1:0]       o_mem_addr,
    output logic [mips_pkg::XLEN-1:0]       o_mem_wdata,
    output logic                            o_halted
);
    import mips_pkg::*;

    opcode_e               id_opcode;
    funct_e                id_funct;
    alu_op_e               alu_op;
    logic                  reg_write, reg_dst_rd, alu_src_imm, mem_read;
    logic                  mem_write, mem_to_reg, branch, jump;
    logic [REG_ADDR_W-1:0] ra1, ra2, rf_wa, id_rs, id_rt, ex_rt;
    logic [XLEN-1:0]       rd1, rd2, rf_wd;
    logic                  rf_we, ex_mem_read, id_take_branch;

    pipe_ctrl_if u_ctrl_if ();  // Hazard levels

    mips_pipeline #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_pipe (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_imem_we        (i_imem_we),
        .i_imem_addr      (i_imem_addr),
        .i_imem_wdata     (i_imem_wdata),
        .ctrl             (u_ctrl_if.pipe),
        .o_id_opcode      (id_opcode),
        .o_id_funct       (id_funct),
        .i_reg_write      (reg_write),
        .i_reg_dst_rd     (reg_dst_rd),
        .i_alu_src_imm    (alu_src_imm),
        .i_mem_read       (mem_read),
        .i_mem_write      (mem_write),
        .i_mem_to_reg     (mem_to_reg),
        .i_branch         (branch),
        .i_jump           (jump),
        .i_alu_op         (alu_op),
        .o_ra1            (ra1),
        .o_ra2            (ra2),
        .i_rd1            (rd1),
        .i_rd2            (rd2),
        .o_rf_we          (rf_we),
        .o_rf_wa          (rf_wa),
        .o_rf_wd          (rf_wd),
        .o_id_rs          (id_rs),
        .o_id_rt          (id_rt),
        .o_ex_rt          (ex_rt),
        .o_ex_mem_read    (ex_mem_read),
        .o_id_take_branch (id_take_branch),
        .o_wb_valid       (o_wb_valid),
        .o_wb_rd          (o_wb_rd),
        .o_wb_data        (o_wb_data),
        .o_mem_we         (o_mem_we),
        .o_mem_addr       (o_mem_addr),
        .o_mem_wdata      (o_mem_wdata),
        .o_halted         (o_halted)
    );

    control_decoder u_dec (
        .i_opcode      (id_opcode),
        .i_funct       (id_funct),
        .o_reg_write   (reg_write),
        .o_reg_dst_rd  (reg_dst_rd),
        .o_alu_src_imm (alu_src_imm),
        .o_mem_read    (mem_read),
        .o_mem_write   (mem_write),
        .o_mem_to_reg  (mem_to_reg),
        .o_branch      (branch),
        .o_jump        (jump),
        .o_alu_op      (alu_op)
    );

    hazard_detection u_hazard (
        .i_if_id_rs       (id_rs),
        .i_if_id_rt       (id_rt),
        .i_id_ex_rt       (ex_rt),
        .i_if_id_opcode   (id_opcode),
        .i_id_ex_mem_read (ex_mem_read),
        .i_id_take_branch (id_take_branch),
        .o_ctrl           (u_ctrl_if.hazard)
    );

    register_file u_rf (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_ra1   (ra1),
        .i_ra2   (ra2),
        .o_rd1   (rd1),
        .o_rd2   (rd2),
        .i_we    (rf_we),
        .i_wa    (rf_wa),
        .i_wd    (rf_wd)
    );

endmodule

/* rtl/mips_pipeline.sv */
`timescale 1ns/10ps

module mips_pipeline #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 64
) (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_imem_we,       // Program load, word index
    input  logic [$clog2(IMEM_DEPTH)-1:0]   i_imem_addr,
    input  logic [mips_pkg::XLEN-1:0]       i_imem_wdata,
    pipe_ctrl_if.pipe                       ctrl,
    output mips_pkg::opcode_e               o_id_opcode,
    output mips_pkg::funct_e                o_id_funct,
    input  logic                            i_reg_write,
    input  logic                            i_reg_dst_rd,
    input  logic                            i_alu_src_imm,
    input  logic                            i_mem_read,
    input  logic                            i_mem_write,
    input  logic                            i_mem_to_reg,
    input  logic                            i_branch,
    input  logic                            i_jump,
    input  mips_pkg::alu_op_e               i_alu_op,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_ra1,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_ra2,
    input  logic [mips_pkg::XLEN-1:0]       i_rd1,
    input  logic [mips_pkg::XLEN-1:0]       i_rd2,
    output logic                            o_rf_we,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_rf_wa,
    output logic [mips_pkg::XLEN-1:0]       o_rf_wd,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_id_rs,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_id_rt,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_ex_rt,
    output logic                            o_ex_mem_read,
    output logic                            o_id_take_branch,
    output logic                            o_wb_valid,      // One strobe per register write
    output logic [mips_pkg::REG_ADDR_W-1:0] o_wb_rd,
    output logic [mips_pkg::XLEN-1:0]       o_wb_data,
    output logic                            o_mem_we,        // Store in MEM
    output logic [mips_pkg::XLEN-1:0]       o_mem_addr,
    output logic [mips_pkg::XLEN-1:0]       o_mem_wdata,
    output logic                            o_halted
);
    import mips_pkg::*;

    localparam int IA_W = $clog2(IMEM_DEPTH);
    localparam int DA_W = $clog2(DMEM_DEPTH);

    logic [XLEN-1:0] imem [IMEM_DEPTH];
    logic [XLEN-1:0] dmem [DMEM_DEPTH];

    logic [XLEN-1:0] pc, pc_plus4;
    logic            halt_q;      // HALT has left ID, fetch stays off
    logic            fetch_stop;
    logic [XLEN-1:0] if_id_instr, if_id_pc4;

    logic [REG_ADDR_W-1:0] id_dst;
    logic [XLEN-1:0]       id_imm, br_target, j_target;

    logic                  id_ex_reg_write, id_ex_mem_read, id_ex_mem_write;
    logic                  id_ex_mem_to_reg, id_ex_alu_src_imm, id_ex_halt;
    alu_op_e               id_ex_alu_op;
    logic [REG_ADDR_W-1:0] id_ex_rs, id_ex_rt, id_ex_dst;
    logic [XLEN-1:0]       id_ex_rd1, id_ex_rd2, id_ex_imm;
    logic [XLEN-1:0]       fwd_a, fwd_b, alu_y;

    logic                  ex_mem_reg_write, ex_mem_mem_write, ex_mem_mem_to_reg, ex_mem_halt;
    logic [REG_ADDR_W-1:0] ex_mem_dst;
    logic [XLEN-1:0]       ex_mem_alu_y, ex_mem_wdata, mem_result;

    logic                  mem_wb_reg_write, mem_wb_halt, halted_q;
    logic [REG_ADDR_W-1:0] mem_wb_dst;
    logic [XLEN-1:0]       mem_wb_data;

    // IF
    assign pc_plus4   = pc + XLEN'(4);
    assign fetch_stop = ctrl.halt | halt_q;

    always_ff @(posedge i_clk) begin
        if (i_imem_we) imem[i_imem_addr] <= i_imem_wdata;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc     <= '0;
            halt_q <= 1'b0;
        end else begin
            if (ctrl.halt && !ctrl.stall) halt_q <= 1'b1;
            if (ctrl.ctrl_hazard) pc <= i_jump ? j_target : br_target;  // Redirect from ID
            else if (!ctrl.stall && !fetch_stop) pc <= pc_plus4;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            if_id_instr <= '0;  // Zero word decodes as a bubble
        end else if (!ctrl.stall) begin
            if (ctrl.flush_if_id || fetch_stop) if_id_instr <= '0;
            else if_id_instr <= imem[pc[IA_W+1:2]];
        end
    end

    always_ff @(posedge i_clk) begin
        if (!ctrl.stall) if_id_pc4 <= pc_plus4;
    end

    // ID, branch compare uses raw register reads
    assign o_id_opcode      = opcode_e'(if_id_instr[31:26]);
    assign o_id_funct       = funct_e'(if_id_instr[5:0]);
    assign o_id_rs          = if_id_instr[25:21];
    assign o_id_rt          = if_id_instr[20:16];
    assign o_ra1            = o_id_rs;
    assign o_ra2            = o_id_rt;
    assign id_dst           = i_reg_dst_rd ? if_id_instr[15:11] : o_id_rt;
    assign id_imm           = {{(XLEN-16){if_id_instr[15]}}, if_id_instr[15:0]};
    assign br_target        = if_id_pc4 + {id_imm[XLEN-3:0], 2'b00};
    assign j_target         = {if_id_pc4[XLEN-1:28], if_id_instr[25:0], 2'b00};
    assign o_id_take_branch = i_jump | (i_branch & (i_rd1 == i_rd2));

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || ctrl.flush_id_ex) begin
            id_ex_reg_write   <= 1'b0;
            id_ex_mem_read    <= 1'b0;
            id_ex_mem_write   <= 1'b0;
            id_ex_mem_to_reg  <= 1'b0;
            id_ex_alu_src_imm <= 1'b0;
            id_ex_halt        <= 1'b0;
        end else begin
            id_ex_reg_write   <= i_reg_write;
            id_ex_mem_read    <= i_mem_read;
            id_ex_mem_write   <= i_mem_write;
            id_ex_mem_to_reg  <= i_mem_to_reg;
            id_ex_alu_src_imm <= i_alu_src_imm;
            id_ex_halt        <= ctrl.halt;  // Marker rides down to WB
        end
    end

    always_ff @(posedge i_clk) begin
        id_ex_alu_op <= i_alu_op;
        id_ex_rs     <= o_id_rs;
        id_ex_rt     <= o_id_rt;
        id_ex_dst    <= id_dst;
        id_ex_rd1    <= i_rd1;
        id_ex_rd2    <= i_rd2;
        id_ex_imm    <= id_imm;
    end

    // EX, newest producer wins
    assign o_ex_rt       = id_ex_rt;
    assign o_ex_mem_read = id_ex_mem_read;
    assign fwd_a = (ex_mem_reg_write && ex_mem_dst != '0 && ex_mem_dst == id_ex_rs) ? ex_mem_alu_y :
                   (mem_wb_reg_write && mem_wb_dst != '0 && mem_wb_dst == id_ex_rs) ? mem_wb_data :
                   id_ex_rd1;
    assign fwd_b = (ex_mem_reg_write && ex_mem_dst != '0 && ex_mem_dst == id_ex_rt) ? ex_mem_alu_y :
                   (mem_wb_reg_write && mem_wb_dst != '0 && mem_wb_dst == id_ex_rt) ? mem_wb_data :
                   id_ex_rd2;

    alu u_alu (
        .i_a  (fwd_a),
        .i_b  (id_ex_alu_src_imm ? id_ex_imm : fwd_b),
        .i_op (id_ex_alu_op),
        .o_y  (alu_y)
    );

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ex_mem_reg_write  <= 1'b0;
            ex_mem_mem_write  <= 1'b0;
            ex_mem_mem_to_reg <= 1'b0;
            ex_mem_halt       <= 1'b0;
        end else begin
            ex_mem_reg_write  <= id_ex_reg_write;
            ex_mem_mem_write  <= id_ex_mem_write;
            ex_mem_mem_to_reg <= id_ex_mem_to_reg;
            ex_mem_halt       <= id_ex_halt;
        end
    end

    always_ff @(posedge i_clk) begin
        ex_mem_alu_y <= alu_y;
        ex_mem_wdata <= fwd_b;  // Store data after forwarding
        ex_mem_dst   <= id_ex_dst;
    end

    // MEM, word index from byte address
    assign mem_result = ex_mem_mem_to_reg ? dmem[ex_mem_alu_y[DA_W+1:2]] : ex_mem_alu_y;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < DMEM_DEPTH; i++) dmem[i] <= '0;
        end else if (ex_mem_mem_write) begin
            dmem[ex_mem_alu_y[DA_W+1:2]] <= ex_mem_wdata;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            mem_wb_reg_write <= 1'b0;
            mem_wb_halt      <= 1'b0;
            halted_q         <= 1'b0;
        end else begin
            mem_wb_reg_write <= ex_mem_reg_write;
            mem_wb_halt      <= ex_mem_halt;
            if (mem_wb_halt) halted_q <= 1'b1;  // Sticky once HALT retires
        end
    end

    always_ff @(posedge i_clk) begin
        mem_wb_data <= mem_result;
        mem_wb_dst  <= ex_mem_dst;
    end

    // WB and trace
    assign o_rf_we     = mem_wb_reg_write;
    assign o_rf_wa     = mem_wb_dst;
    assign o_rf_wd     = mem_wb_data;
    assign o_wb_valid  = mem_wb_reg_write;
    assign o_wb_rd     = mem_wb_dst;
    assign o_wb_data   = (mem_wb_dst == '0) ? '0 : mem_wb_data;  // $0 traces as zero
    assign o_mem_we    = ex_mem_mem_write;
    assign o_mem_addr  = ex_mem_alu_y;
    assign o_mem_wdata = ex_mem_wdata;
    assign o_halted    = halted_q | mem_wb_halt;

endmodule

/* rtl/alu.sv */
`timescale 1ns/10ps

module alu (
    input  logic [mips_pkg::XLEN-1:0] i_a,
    input  logic [mips_pkg::XLEN-1:0] i_b,
    input  mips_pkg::alu_op_e         i_op,
    output logic [mips_pkg::XLEN-1:0] o_y
);
    import mips_pkg::*;

    logic lt;

    assign lt = $signed(i_a) < $signed(i_b);  // SLT is signed

    always_comb begin
        case (i_op)
            ALU_ADD: o_y = i_a + i_b;  // ADDU, ADDIU, address calc
            ALU_SUB: o_y = i_a - i_b;
            ALU_AND: o_y = i_a & i_b;
            ALU_OR:  o_y = i_a | i_b;
            ALU_SLT: o_y = {{(XLEN-1){1'b0}}, lt};
            default: o_y = '0;
        endcase
    end

endmodule

/* rtl/register_file.sv */
`timescale 1ns/10ps

module register_file (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_ra1,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_ra2,
    output logic [mips_pkg::XLEN-1:0]       o_rd1,
    output logic [mips_pkg::XLEN-1:0]       o_rd2,
    input  logic                            i_we,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_wa,
    input  logic [mips_pkg::XLEN-1:0]       i_wd
);
    import mips_pkg::*;

    localparam int NREGS = 1 << REG_ADDR_W;

    logic [XLEN-1:0] regs [1:NREGS-1];  // No storage for $0

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_wa != '0)) begin
            regs[i_wa] <= i_wd;
        end
    end

    // $0 reads zero, a same-cycle write is seen by ID
    assign o_rd1 = (i_ra1 == '0)               ? '0   :
                   (i_we && (i_wa == i_ra1))   ? i_wd : regs[i_ra1];
    assign o_rd2 = (i_ra2 == '0)               ? '0   :
                   (i_we && (i_wa == i_ra2))   ? i_wd : regs[i_ra2];

endmodule

/* rtl/control_decoder.sv */
`timescale 1ns/10ps

module control_decoder (
    input  mips_pkg::opcode_e i_opcode,
    input  mips_pkg::funct_e  i_funct,
    output logic              o_reg_write,
    output logic              o_reg_dst_rd,   // rd is destination, else rt
    output logic              o_alu_src_imm,  // B operand from sign-extended imm
    output logic              o_mem_read,
    output logic              o_mem_write,
    output logic              o_mem_to_reg,   // WB takes load data
    output logic              o_branch,
    output logic              o_jump,
    output mips_pkg::alu_op_e o_alu_op
);
    import mips_pkg::*;

    always_comb begin
        // Defaults give a no-op, also for unknown codes
        o_reg_write   = 1'b0;
        o_reg_dst_rd  = 1'b0;
        o_alu_src_imm = 1'b0;
        o_mem_read    = 1'b0;
        o_mem_write   = 1'b0;
        o_mem_to_reg  = 1'b0;
        o_branch      = 1'b0;
        o_jump        = 1'b0;
        o_alu_op      = ALU_ADD;
        case (i_opcode)
            OP_RTYPE: begin
                o_reg_dst_rd = 1'b1;
                o_reg_write  = 1'b1;
                case (i_funct)
                    FN_ADDU: o_alu_op = ALU_ADD;
                    FN_SUBU: o_alu_op = ALU_SUB;
                    FN_AND:  o_alu_op = ALU_AND;
                    FN_OR:   o_alu_op = ALU_OR;
                    FN_SLT:  o_alu_op = ALU_SLT;
                    default: o_reg_write = 1'b0;  // All-zero bubble lands here
                endcase
            end
            OP_ADDIU: begin
                o_reg_write   = 1'b1;
                o_alu_src_imm = 1'b1;
            end
            OP_LW: begin
                o_reg_write   = 1'b1;
                o_alu_src_imm = 1'b1;  // Address = rs + imm
                o_mem_read    = 1'b1;
                o_mem_to_reg  = 1'b1;
            end
            OP_SW: begin
                o_alu_src_imm = 1'b1;
                o_mem_write   = 1'b1;
            end
            OP_BEQ:  o_branch = 1'b1;  // Compare done in ID
            OP_J:    o_jump   = 1'b1;
            default: o_reg_write = 1'b0;  // HALT and narrow loads fall through as no-ops
        endcase
    end

endmodule

/* rtl/hazard_detection.sv */
`timescale 1ns/10ps

module hazard_detection (
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_if_id_rs,        // ID source rs
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_if_id_rt,        // ID rt, source unless a load
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_id_ex_rt,        // Load target in EX
    input  mips_pkg::opcode_e               i_if_id_opcode,
    input  logic                            i_id_ex_mem_read,  // EX holds a load
    input  logic                            i_id_take_branch,  // Branch or jump taken in ID
    pipe_ctrl_if.hazard                     o_ctrl
);
    import mips_pkg::*;

    logic is_load_in_id;
    logic load_use;

    // Loads write rt, so their rt is no source
    assign is_load_in_id = i_if_id_opcode inside {OP_LW, OP_LH, OP_LB, OP_LHU, OP_LBU, OP_LWU};

    // Data not ready until MEM finishes
    assign load_use = i_id_ex_mem_read && (i_id_ex_rt != '0) &&
                      ((i_id_ex_rt == i_if_id_rs) ||
                       ((i_id_ex_rt == i_if_id_rt) && !is_load_in_id));

    // Taken branch overrides the stall, ID instruction leaves anyway
    assign o_ctrl.stall       = load_use && !i_id_take_branch;
    assign o_ctrl.flush_id_ex = load_use;
    assign o_ctrl.flush_if_id = i_id_take_branch;  // Kill wrong-path fetch
    assign o_ctrl.ctrl_hazard = i_id_take_branch;
    assign o_ctrl.halt        = (i_if_id_opcode == OP_HALT);

endmodule

/* rtl/pipe_ctrl_if.sv */
`timescale 1ns/10ps

// Hazard levels from the hazard block to the pipeline, all combinational
interface pipe_ctrl_if;

    logic stall;        // Load-use, hold PC and IF/ID
    logic flush_id_ex;  // Bubble into ID/EX
    logic flush_if_id;  // Taken branch or jump kills the fetched word
    logic ctrl_hazard;  // Redirect PC to the ID target
    logic halt;         // HALT in ID

    modport hazard (
        output stall,
        output flush_id_ex,
        output flush_if_id,
        output ctrl_hazard,
        output halt
    );

    modport pipe (
        input stall,
        input flush_id_ex,
        input flush_if_id,
        input ctrl_hazard,
        input halt
    );

endinterface

/* rtl/mips_pkg.sv */
package mips_pkg;

    localparam int XLEN       = 32;  // Data path width
    localparam int REG_ADDR_W = 5;   // 32 architectural registers

    // Primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDIU = 6'h09,
        OP_LB    = 6'h20,
        OP_LH    = 6'h21,
        OP_LW    = 6'h23,
        OP_LBU   = 6'h24,
        OP_LHU   = 6'h25,
        OP_LWU   = 6'h27,
        OP_SW    = 6'h2B,
        OP_HALT  = 6'h3F   // Stops fetch, drains the pipe
    } opcode_e;

    // R-type function field, instr[5:0]
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2A
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4   // Signed compare
    } alu_op_e;

endpackage
